//--- design/keypad_pkg.sv
package keypad_pkg;

    localparam int NUM_PADS         = 4;
    localparam int NUM_ROWS         = 4;
    localparam int NUM_COLS         = 4;
    localparam int PAD_IDX_W        = 2;
    localparam int KEY_CODE_W       = 4;       // Row index times 4 plus column index
    localparam int DEBOUNCE_TICKS   = 20;      // Ticks between first and second scan
    localparam int DEFAULT_TICK_DIV = 100000;  // 1 ms at 100 MHz
    localparam int FIFO_DEPTH       = 4;

    // Derived widths
    localparam int ROW_IDX_W  = $clog2(NUM_ROWS);
    localparam int COL_IDX_W  = $clog2(NUM_COLS);
    localparam int DEB_CNT_W  = $clog2(DEBOUNCE_TICKS);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Scanner output, row and column index in one byte
    typedef struct packed {
        logic [3:0] row;
        logic [3:0] col;
    } key_coord_t;

    // Queue entry and top-level output
    typedef struct packed {
        logic [PAD_IDX_W-1:0]  pad;
        logic [KEY_CODE_W-1:0] code;
    } key_event_t;

    typedef enum logic [2:0] {
        st_idle,
        st_scan_first,
        st_debounce,
        st_scan_second,
        st_wait_release
    } scan_state_t;

endpackage

//--- design/scan_tick_gen.sv
`timescale 1ns/100ps

module scan_tick_gen
    import keypad_pkg::*;
#(
    parameter int tick_div = DEFAULT_TICK_DIV
) (
    input  logic clk,
    input  logic rst_n,
    output logic scan_tick
);

    localparam int CNT_W = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [CNT_W-1:0] tick_cnt;
    logic             wrap;

    assign wrap = (tick_cnt == CNT_W'(tick_div - 1));

    // One counter paces every pad so all scanners step in lockstep
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt  <= '0;
            scan_tick <= 1'b0;
        end else begin
            scan_tick <= wrap;                  // Registered pulse on the wrap
            if (wrap) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/keypad_scanner.sv
`timescale 1ns/100ps

module keypad_scanner
    import keypad_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                scan_tick,
    input  logic [NUM_ROWS-1:0] row_in,
    output logic [NUM_COLS-1:0] col_out,
    output logic                press_strobe,
    output key_coord_t          press_coord
);

    logic [NUM_ROWS-1:0]  row_meta;
    logic [NUM_ROWS-1:0]  row_sync;
    scan_state_t          state;
    logic [COL_IDX_W-1:0] col_idx;
    logic [DEB_CNT_W-1:0] deb_cnt;
    key_coord_t           first_coord;

    logic [NUM_ROWS-1:0]  row_low;
    logic                 any_low;
    logic                 one_low;
    logic [ROW_IDX_W-1:0] row_idx;
    key_coord_t           cur_coord;
    logic                 last_col;

    // Active-low drive pattern for a single column
    function automatic logic [NUM_COLS-1:0] col_drive(input logic [COL_IDX_W-1:0] idx);
        return ~(NUM_COLS'(1) << idx);
    endfunction

    // Two-flop row synchronizer, idles at all high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_meta <= '1;
            row_sync <= '1;
        end else begin
            row_meta <= row_in;
            row_sync <= row_meta;
        end
    end

    // Encode the low rows of the current pattern
    always_comb begin
        row_low = ~row_sync;
        any_low = |row_low;
        one_low = any_low && ((row_low & (row_low - 1'b1)) == '0);
        row_idx = '0;
        for (int r = NUM_ROWS - 1; r >= 0; r--) begin
            if (row_low[r]) begin
                row_idx = ROW_IDX_W'(r);
            end
        end
    end

    always_comb begin
        cur_coord.row = 4'(row_idx);
        cur_coord.col = 4'(col_idx);
        last_col      = (col_idx == COL_IDX_W'(NUM_COLS - 1));
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= st_idle;
            col_idx      <= '0;
            deb_cnt      <= '0;
            col_out      <= '0;
            press_strobe <= 1'b0;
        end else begin
            press_strobe <= 1'b0;
            if (scan_tick) begin
                case (state)
                    st_idle: begin
                        if (any_low) begin
                            state   <= st_scan_first;
                            col_idx <= '0;
                            col_out <= col_drive('0);
                        end
                    end
                    st_scan_first, st_scan_second: begin
                        if (!any_low) begin
                            if (last_col) begin
                                state   <= st_idle;     // Nothing found in any column
                                col_out <= '0;
                            end else begin
                                col_idx <= col_idx + 1'b1;
                                col_out <= col_drive(col_idx + 1'b1);
                            end
                        end else begin
                            col_out <= '0;
                            if (!one_low) begin
                                state <= st_wait_release;   // Ghosting
                            end else if (state == st_scan_first) begin
                                state   <= st_debounce;
                                deb_cnt <= '0;
                            end else begin
                                state        <= st_wait_release;
                                press_strobe <= (cur_coord == first_coord);
                            end
                        end
                    end
                    st_debounce: begin
                        if (!any_low) begin
                            state <= st_idle;           // Bounce or short tap
                        end else if (deb_cnt == DEB_CNT_W'(DEBOUNCE_TICKS - 1)) begin
                            state   <= st_scan_second;
                            col_idx <= '0;
                            col_out <= col_drive('0);
                        end else begin
                            deb_cnt <= deb_cnt + 1'b1;
                        end
                    end
                    st_wait_release: begin
                        if (!any_low) begin
                            state <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_tick && one_low) begin
            if (state == st_scan_first) begin
                first_coord <= cur_coord;
            end
            if (state == st_scan_second) begin
                press_coord <= cur_coord;       // Valid with the strobe
            end
        end
    end

endmodule

//--- design/key_event_collector.sv
`timescale 1ns/100ps

module key_event_collector
    import keypad_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_PADS-1:0] press_strobe,
    input  key_coord_t          press_coord [NUM_PADS],
    input  logic                key_pop,
    output key_event_t          key_event,
    output logic                fifo_empty,
    output logic                overflow
);

    logic [NUM_PADS-1:0]   pending;
    key_coord_t            held_coord [NUM_PADS];
    logic [PAD_IDX_W-1:0]  rr_ptr;
    logic                  grant_valid;
    logic [PAD_IDX_W-1:0]  grant_idx;
    logic [NUM_PADS-1:0]   served;
    key_event_t            new_event;

    key_event_t            fifo_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] fifo_cnt;
    logic                  fifo_full;
    logic                  do_push;
    logic                  do_pop;

    // Search starts at the pad after the last one served
    always_comb begin : rr_search
        logic [PAD_IDX_W-1:0] idx;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int i = 1; i <= NUM_PADS; i++) begin
            idx = PAD_IDX_W'(rr_ptr + i);
            if (!grant_valid && pending[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = idx;
            end
        end
    end

    assign served = grant_valid ? (NUM_PADS'(1) << grant_idx) : '0;

    always_comb begin
        new_event.pad  = grant_idx;
        new_event.code = KEY_CODE_W'(held_coord[grant_idx].row * NUM_COLS
                                     + held_coord[grant_idx].col);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
            rr_ptr  <= PAD_IDX_W'(NUM_PADS - 1);   // First search begins at pad 0
        end else begin
            for (int p = 0; p < NUM_PADS; p++) begin
                if (served[p]) begin
                    pending[p] <= press_strobe[p];
                end else if (press_strobe[p]) begin
                    pending[p] <= 1'b1;
                end
            end
            if (grant_valid) begin
                rr_ptr <= grant_idx;
            end
        end
    end

    // Hold the coordinate until the pad is served
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PADS; p++) begin
            if (press_strobe[p] && (!pending[p] || served[p])) begin
                held_coord[p] <= press_coord[p];
            end
        end
    end

    assign fifo_full  = (fifo_cnt == FIFO_CNT_W'(FIFO_DEPTH));
    assign fifo_empty = (fifo_cnt == '0);
    assign do_push    = grant_valid && !fifo_full;
    assign do_pop     = key_pop && !fifo_empty;
    assign key_event  = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
            if (grant_valid && fifo_full) begin
                overflow <= 1'b1;                   // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= new_event;
        end
    end

endmodule

//--- design/keypad_subsystem.sv
`timescale 1ns/100ps

module keypad_subsystem
    import keypad_pkg::*;
#(
    parameter int tick_div = DEFAULT_TICK_DIV
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_ROWS-1:0] row_in [NUM_PADS],
    output logic [NUM_COLS-1:0] col_out [NUM_PADS],
    input  logic                key_pop,
    output key_event_t          key_event,
    output logic                fifo_empty,
    output logic                overflow
);

    logic                scan_tick;
    logic [NUM_PADS-1:0] press_strobe;
    key_coord_t          press_coord [NUM_PADS];

    scan_tick_gen #(
        .tick_div (tick_div)
    ) i_scan_tick_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_tick (scan_tick)
    );

    // One scanner per keypad, all paced by the same tick
    for (genvar p = 0; p < NUM_PADS; p++) begin : g_pad
        keypad_scanner i_keypad_scanner (
            .clk          (clk),
            .rst_n        (rst_n),
            .scan_tick    (scan_tick),
            .row_in       (row_in[p]),
            .col_out      (col_out[p]),
            .press_strobe (press_strobe[p]),
            .press_coord  (press_coord[p])
        );
    end

    key_event_collector i_key_event_collector (
        .clk          (clk),
        .rst_n        (rst_n),
        .press_strobe (press_strobe),
        .press_coord  (press_coord),
        .key_pop      (key_pop),
        .key_event    (key_event),
        .fifo_empty   (fifo_empty),
        .overflow     (overflow)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;     // 20 ns period
        end
    end

endmodule

//--- test/keypad_matrix_model.sv
`timescale 1ns/100ps

module keypad_matrix_model
    import keypad_pkg::*;
(
    input  logic [NUM_COLS-1:0]          col_out,
    input  logic [NUM_ROWS*NUM_COLS-1:0] pressed,
    output logic [NUM_ROWS-1:0]          row_in
);

    // A closed key shorts its row to its column, open rows float high
    always_comb begin
        row_in = '1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (pressed[r * NUM_COLS + c] && col_out[c] === 1'b0) begin
                    row_in[r] = 1'b0;
                end
            end
        end
    end

endmodule

//--- test/tb_keypad_subsystem.sv
`timescale 1ns/100ps

module tb_keypad_subsystem
    import keypad_pkg::*;
();

    localparam int TICK_DIV      = 8;
    localparam int LONG_HOLD     = DEBOUNCE_TICKS + 12;
    localparam int SETTLE        = 4;
    localparam int EVENT_TIMEOUT = 60;     // In ticks

    logic                         clk;
    logic                         rst_n;
    wire  [NUM_ROWS-1:0]          row_in [NUM_PADS];
    wire  [NUM_COLS-1:0]          col_out [NUM_PADS];
    logic                         key_pop;
    key_event_t                   key_event;
    logic                         fifo_empty;
    logic                         overflow;

    logic [NUM_ROWS*NUM_COLS-1:0] pressed [NUM_PADS];
    logic [NUM_ROWS*NUM_COLS-1:0] stim_mask [NUM_PADS];
    logic                         auto_pop;
    key_event_t                   got_q [$];
    key_event_t                   exp_q [$];
    int                           got_rd;
    int unsigned                  rng_state;
    int                           check_count;
    int                           error_count;

    tb_clock_gen i_tb_clock_gen (
        .clk (clk)
    );

    keypad_subsystem #(
        .tick_div (TICK_DIV)
    ) i_keypad_subsystem (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_in     (row_in),
        .col_out    (col_out),
        .key_pop    (key_pop),
        .key_event  (key_event),
        .fifo_empty (fifo_empty),
        .overflow   (overflow)
    );

    for (genvar p = 0; p < NUM_PADS; p++) begin : g_model
        keypad_matrix_model i_keypad_matrix_model (
            .col_out (col_out[p]),
            .pressed (pressed[p]),
            .row_in  (row_in[p])
        );
    end

    // Pop every other cycle, so the head captured with key_pop high is the one removed
    always @(posedge clk) begin
        if (!rst_n) begin
            key_pop <= 1'b0;
        end else if (key_pop) begin
            got_q.push_back(key_event);
            key_pop <= 1'b0;
        end else if (auto_pop && !fifo_empty) begin
            key_pop <= 1'b1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned random_below(input int unsigned range);
        rng_state = xorshift32(rng_state);
        return rng_state % range;
    endfunction

    function automatic key_event_t make_event(input int pad, input int row, input int col);
        key_event_t ev;
        ev.pad  = PAD_IDX_W'(pad);
        ev.code = KEY_CODE_W'(row * NUM_COLS + col);    // Row times 4 plus column
        return ev;
    endfunction

    task automatic wait_ticks(input int n);
        repeat (n * TICK_DIV) @(posedge clk);
    endtask

    task automatic drive_masks();
        @(posedge clk);
        for (int p = 0; p < NUM_PADS; p++) begin
            pressed[p] <= stim_mask[p];
        end
    endtask

    task automatic clear_masks();
        for (int p = 0; p < NUM_PADS; p++) begin
            stim_mask[p] = '0;
        end
    endtask

    task automatic hold_keys(input int hold);
        drive_masks();
        wait_ticks(hold);
        clear_masks();
        drive_masks();
        wait_ticks(SETTLE);     // Lets wait_release see the rows high
    endtask

    task automatic press_key(input int pad, input int row, input int col, input int hold);
        clear_masks();
        stim_mask[pad][row * NUM_COLS + col] = 1'b1;
        hold_keys(hold);
    endtask

    task automatic wait_for_events(input int n);
        int cycles;
        cycles = 0;
        while ((got_q.size() - got_rd) < n && cycles < EVENT_TIMEOUT * TICK_DIV) begin
            @(negedge clk);
            cycles++;
        end
        if ((got_q.size() - got_rd) < n) begin
            error_count++;
            $display("Timeout at %0t: waited for %0d events but only %0d arrived",
                     $time, n, got_q.size() - got_rd);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic check_event_count();
        @(negedge clk);
        check_count++;
        assert ((got_q.size() - got_rd) == exp_q.size()) else begin
            error_count++;
            $display("Wrong number of events at %0t: expected %0d but %0d were popped",
                     $time, exp_q.size(), got_q.size() - got_rd);
        end
    endtask

    task automatic check_events_in_order();
        check_event_count();
        for (int i = 0; i < exp_q.size() && got_rd + i < got_q.size(); i++) begin
            check_count++;
            assert (got_q[got_rd + i] == exp_q[i]) else begin
                error_count++;
                $display("[FAIL] %0t key_event expected pad %0d code %0d got pad %0d code %0d",
                         $time, exp_q[i].pad, exp_q[i].code,
                         got_q[got_rd + i].pad, got_q[got_rd + i].code);
            end
        end
        got_rd = got_q.size();
        exp_q.delete();
    endtask

    task automatic check_events_as_set();
        key_event_t rest [$];
        int         hit;
        check_event_count();
        for (int i = got_rd; i < got_q.size(); i++) begin
            rest.push_back(got_q[i]);
        end
        foreach (exp_q[e]) begin
            hit = -1;
            foreach (rest[i]) begin
                if (hit < 0 && rest[i] == exp_q[e]) begin
                    hit = i;
                end
            end
            check_count++;
            assert (hit >= 0) else begin
                error_count++;
                $display("Missing event at %0t: pad %0d code %0d was never popped",
                         $time, exp_q[e].pad, exp_q[e].code);
            end
            if (hit >= 0) begin
                rest.delete(hit);   // Matched once, so a duplicate cannot match again
            end
        end
        got_rd = got_q.size();
        exp_q.delete();
    endtask

    initial begin : stimulus
        int pad;
        int row;
        int row2;
        int col;
        rst_n       = 1'b0;
        key_pop     = 1'b0;
        auto_pop    = 1'b0;
        got_rd      = 0;
        rng_state   = 22911;
        check_count = 0;
        error_count = 0;
        for (int p = 0; p < NUM_PADS; p++) begin
            pressed[p]   = '0;
            stim_mask[p] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        for (int p = 0; p < NUM_PADS; p++) begin
            check_value($sformatf("col_out[%0d]", p), col_out[p], 0);
        end
        check_value("fifo_empty", fifo_empty, 1);
        check_value("overflow", overflow, 0);
        @(posedge clk);
        auto_pop <= 1'b1;

        repeat (4) begin                        // Long single presses
            pad = random_below(NUM_PADS);
            row = random_below(NUM_ROWS);
            col = random_below(NUM_COLS);
            exp_q.push_back(make_event(pad, row, col));
            press_key(pad, row, col, LONG_HOLD + random_below(8));
            wait_for_events(1);
            wait_ticks(SETTLE);
            check_events_in_order();
        end

        repeat (4) begin                        // Short taps
            pad = random_below(NUM_PADS);
            row = random_below(NUM_ROWS);
            col = random_below(NUM_COLS);
            press_key(pad, row, col, 1 + random_below(DEBOUNCE_TICKS - 1));
            wait_ticks(LONG_HOLD);
            check_events_in_order();
        end

        // Two rows in one column look like ghosting
        pad  = random_below(NUM_PADS);
        col  = random_below(NUM_COLS);
        row  = random_below(NUM_ROWS);
        row2 = (row + 1 + random_below(NUM_ROWS - 1)) % NUM_ROWS;
        clear_masks();
        stim_mask[pad][row * NUM_COLS + col]  = 1'b1;
        stim_mask[pad][row2 * NUM_COLS + col] = 1'b1;
        hold_keys(LONG_HOLD);
        wait_ticks(LONG_HOLD);
        check_events_in_order();

        clear_masks();                          // All pads pressed together
        for (int p = 0; p < NUM_PADS; p++) begin
            row = random_below(NUM_ROWS);
            col = random_below(NUM_COLS);
            stim_mask[p][row * NUM_COLS + col] = 1'b1;
            exp_q.push_back(make_event(p, row, col));
        end
        hold_keys(LONG_HOLD);
        wait_for_events(NUM_PADS);
        wait_ticks(SETTLE);
        check_events_as_set();

        @(posedge clk);
        auto_pop <= 1'b0;
        for (int n = 0; n < FIFO_DEPTH + 2; n++) begin
            pad = random_below(NUM_PADS);
            row = random_below(NUM_ROWS);
            col = random_below(NUM_COLS);
            if (n < FIFO_DEPTH) begin
                exp_q.push_back(make_event(pad, row, col));   // Later ones are dropped
            end
            press_key(pad, row, col, LONG_HOLD);
        end
        @(negedge clk);
        check_value("overflow", overflow, 1);
        check_value("fifo_empty", fifo_empty, 0);
        @(posedge clk);
        auto_pop <= 1'b1;
        wait_for_events(FIFO_DEPTH);
        wait_ticks(SETTLE);
        check_events_in_order();
        check_value("fifo_empty", fifo_empty, 1);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
design/keypad_pkg.sv
design/scan_tick_gen.sv
design/keypad_scanner.sv
design/key_event_collector.sv
design/keypad_subsystem.sv
test/tb_clock_gen.sv
test/keypad_matrix_model.sv
test/tb_keypad_subsystem.sv
